// ==== hdl/crate_defines.svh ====
`ifndef CRATE_DEFINES_SVH
`define CRATE_DEFINES_SVH

// Fiber link
`define CRATE_FIBER_W 16
`define CRATE_SYNC_WORD 16'hAAAA
`define CRATE_FIBER_ID_W 10

// Front-end channels and the fields of a channel word
`define CRATE_CHANNELS 16
`define CRATE_SPARE_W 3
`define CRATE_FIELD_W 6

// Hit map geometry
`define CRATE_ROWS 18
`define CRATE_COLS 38

// Event sequencing
`define CRATE_COLLECT_CYCLES 16
`define CRATE_CNT_W 4

// Header fields, flag in the top bit
`define CRATE_MARKER_W 11
`define CRATE_HDR_MARKER 11'h400
`define CRATE_HDR_FLAG 1'b1

`endif

// ==== hdl/crate_hit_pkg.sv ====
`default_nettype none

`include "crate_defines.svh"

package crate_hit_pkg;

	// Row or column field of a channel word
	typedef logic [`CRATE_FIELD_W-1:0] cell_index_t;

	// One front-end channel word, valid sits at bit 12
	typedef struct packed
	{
		logic [`CRATE_SPARE_W-1:0] spare;
		logic valid;
		cell_index_t col;
		cell_index_t row;
	} channel_word_t;

	// All channels sampled in one cycle
	typedef channel_word_t [`CRATE_CHANNELS-1:0] channel_bus_t;

	// One map row, bit c+1 holds column field c
	typedef logic [`CRATE_COLS-1:0] map_row_t;

	// Index 0 is map row 1
	typedef map_row_t [`CRATE_ROWS-1:0] hit_map_t;

endpackage

`default_nettype wire

// ==== hdl/crate_frame_pkg.sv ====
`default_nettype none

`include "crate_defines.svh"

package crate_frame_pkg;

	// 38-bit header, same width as a map row
	typedef struct packed
	{
		logic flag;
		logic [`CRATE_MARKER_W-1:0] marker;
		logic [`CRATE_FIBER_ID_W-1:0] fiber_id;
		logic [`CRATE_FIBER_W-1:0] sync;
	} frame_header_t;

	// Header followed by the 18 map rows
	typedef struct packed
	{
		frame_header_t header;
		crate_hit_pkg::hit_map_t rows;
	} frame_t;

	// Event sequencer states
	typedef enum logic [1:0]
	{
		IDLE,
		COLLECT,
		EMIT,
		CLEAR
	} seq_state_t;

endpackage

`default_nettype wire

// ==== hdl/crate_hit_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "crate_defines.svh"

module crate_hit_decoder
(
	input crate_hit_pkg::channel_bus_t channels,
	output crate_hit_pkg::hit_map_t set_mask
);

	logic [`CRATE_CHANNELS-1:0] hit_ok;
	crate_hit_pkg::hit_map_t chan_mask [`CRATE_CHANNELS];

	genvar g_ch;

	generate
		for (g_ch = 0; g_ch < `CRATE_CHANNELS; g_ch++)
		begin : g_chan
			// Column 37 and up would fall off the row
			assign hit_ok[g_ch] = channels[g_ch].valid &&
				(channels[g_ch].row < `CRATE_ROWS) &&
				(channels[g_ch].col < `CRATE_COLS - 1);

			// One-hot mask for this channel
			always_comb
			begin
				chan_mask[g_ch] = '0;
				if (hit_ok[g_ch])
				begin
					chan_mask[g_ch][channels[g_ch].row][channels[g_ch].col + 1] = 1'b1;
				end
			end
		end
	endgenerate

	// Duplicate cells merge in the OR
	always_comb
	begin
		set_mask = '0;
		for (int ch = 0; ch < `CRATE_CHANNELS; ch++)
		begin
			set_mask = set_mask | chan_mask[ch];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/crate_hitmap_accumulator.sv ====
`timescale 1ns/1ns
`default_nettype none

module crate_hitmap_accumulator
(
	input logic clk,
	input logic reset,
	input logic collect,
	input logic clear,
	input crate_hit_pkg::hit_map_t set_mask,
	output crate_hit_pkg::hit_map_t map
);

	crate_hit_pkg::hit_map_t map_q;

	// Sticky hit bits, one edge behind collect
	always_ff @(posedge clk)
	begin
		if (reset || clear)
		begin
			map_q <= '0;
		end
		else if (collect)
		begin
			map_q <= map_q | set_mask;
		end
	end

	assign map = map_q;

endmodule

`default_nettype wire

// ==== hdl/crate_frame_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "crate_defines.svh"

module crate_frame_sequencer
(
	input logic clk,
	input logic reset,
	input logic [`CRATE_FIBER_W-1:0] fiber,
	input crate_hit_pkg::hit_map_t map,
	output logic collect,
	output logic clear,
	output logic frame_valid,
	output crate_frame_pkg::frame_t frame
);

	crate_frame_pkg::seq_state_t state;
	crate_frame_pkg::seq_state_t state_next;
	logic [`CRATE_CNT_W-1:0] count;
	logic last_sample;
	crate_frame_pkg::frame_header_t header;

	// Count reaches 15 at the edge of the 16th sample
	assign last_sample = (count == `CRATE_COLLECT_CYCLES - 1);

	always_comb
	begin
		state_next = state;
		case (state)
			crate_frame_pkg::IDLE:
			begin
				if (fiber == `CRATE_SYNC_WORD)
				begin
					state_next = crate_frame_pkg::COLLECT;
				end
			end
			crate_frame_pkg::COLLECT:
			begin
				if (last_sample)
				begin
					state_next = crate_frame_pkg::EMIT;
				end
			end
			crate_frame_pkg::EMIT:
			begin
				state_next = crate_frame_pkg::CLEAR;
			end
			crate_frame_pkg::CLEAR:
			begin
				state_next = crate_frame_pkg::IDLE;
			end
			default:
			begin
				state_next = crate_frame_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= crate_frame_pkg::IDLE;
			count <= '0;
		end
		else
		begin
			state <= state_next;
			if (state == crate_frame_pkg::COLLECT)
			begin
				count <= count + 1'b1;
			end
			else
			begin
				count <= '0;
			end
		end
	end

	// Fiber id comes from the frame cycle itself
	always_comb
	begin
		header.flag = `CRATE_HDR_FLAG;
		header.marker = `CRATE_HDR_MARKER;
		header.fiber_id = fiber[`CRATE_FIBER_ID_W-1:0];
		header.sync = `CRATE_SYNC_WORD;
	end

	// Strobes follow the state they belong to
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			collect <= 1'b0;
			clear <= 1'b0;
			frame_valid <= 1'b0;
			frame <= '0;
		end
		else
		begin
			collect <= (state_next == crate_frame_pkg::COLLECT);
			clear <= (state_next == crate_frame_pkg::CLEAR);
			frame_valid <= (state == crate_frame_pkg::EMIT);
			if (state == crate_frame_pkg::EMIT)
			begin
				frame.header <= header;
				frame.rows <= map;
			end
			else
			begin
				frame <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/crate_mapper.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "crate_defines.svh"

module crate_mapper
(
	input logic clk,
	input logic reset,
	input logic [`CRATE_FIBER_W-1:0] fiber,
	input crate_hit_pkg::channel_bus_t channels,
	output logic frame_valid,
	output crate_frame_pkg::frame_t frame
);

	logic collect;
	logic clear;
	crate_hit_pkg::hit_map_t set_mask;
	crate_hit_pkg::hit_map_t map;

	// Per-cycle hit decode
	crate_hit_decoder u_decoder
	(
		.channels (channels),
		.set_mask (set_mask)
	);

	crate_hitmap_accumulator u_accumulator
	(
		.clk (clk),
		.reset (reset),
		.collect (collect),
		.clear (clear),
		.set_mask (set_mask),
		.map (map)
	);

	// Event framing and output register
	crate_frame_sequencer u_sequencer
	(
		.clk (clk),
		.reset (reset),
		.fiber (fiber),
		.map (map),
		.collect (collect),
		.clear (clear),
		.frame_valid (frame_valid),
		.frame (frame)
	);

endmodule

`default_nettype wire

// ==== tb/crate_mapper_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "crate_defines.svh"

module crate_mapper_chk
(
	input logic clk,
	input logic reset,
	input logic frame_valid,
	input crate_frame_pkg::frame_t frame
);

	logic [`CRATE_ROWS-1:0] row_lsb;
	int assert_failures = 0;

	// No column field maps to bit 0
	always_comb
	begin
		for (int r = 0; r < `CRATE_ROWS; r++)
		begin
			row_lsb[r] = frame.rows[r][0];
		end
	end

	strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
		frame_valid |=> !frame_valid)
		else
		begin
			$error("frame_valid stayed high for two cycles");
			assert_failures++;
		end

	frame_zero_when_idle: assert property (@(posedge clk) disable iff (reset)
		!frame_valid |-> (frame == '0))
		else
		begin
			$error("frame is not zero outside the frame cycle");
			assert_failures++;
		end

	row_lsb_zero: assert property (@(posedge clk) disable iff (reset)
		row_lsb == '0)
		else
		begin
			$error("bit 0 of a frame row is set");
			assert_failures++;
		end

	// Clear and re-arm keep 18 quiet cycles between strobes
	frame_spacing: assert property (@(posedge clk) disable iff (reset)
		frame_valid |=> !frame_valid [*18])
		else
		begin
			$error("two frame_valid pulses less than 19 cycles apart");
			assert_failures++;
		end

endmodule

bind crate_mapper crate_mapper_chk u_chk
(
	.clk (clk),
	.reset (reset),
	.frame_valid (frame_valid),
	.frame (frame)
);

`default_nettype wire

// ==== tb/crate_mapper_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "crate_defines.svh"

module crate_mapper_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLES_PER_TEST = 40;
	localparam int FRAME_WAIT = 20;
	localparam int EXPECT_LATENCY = `CRATE_COLLECT_CYCLES + 1;
	localparam int MAX_TESTS = 16;
	localparam int DEFAULT_IDLE = 2;
	localparam STIM_FILE = "tb/crate_mapper_stimulus.txt";

	logic clk;
	logic reset;
	logic [`CRATE_FIBER_W-1:0] fiber;
	crate_hit_pkg::channel_bus_t channels;
	logic frame_valid;
	crate_frame_pkg::frame_t frame;

	int num_tests = 0;
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	bit stim_loaded = 1'b0;
	bit load_ok;

	// One record per test
	string test_name [MAX_TESTS];
	int idle_cycles [MAX_TESTS];
	int reset_at [MAX_TESTS];
	crate_hit_pkg::channel_bus_t chan_line [MAX_TESTS][`CRATE_COLLECT_CYCLES];
	logic [`CRATE_FIBER_W-1:0] frame_fiber [MAX_TESTS];
	bit expect_frame [MAX_TESTS];
	crate_frame_pkg::frame_header_t exp_header [MAX_TESTS];
	crate_hit_pkg::hit_map_t exp_map [MAX_TESTS];

	crate_mapper u_crate_mapper
	(
		.clk (clk),
		.reset (reset),
		.fiber (fiber),
		.channels (channels),
		.frame_valid (frame_valid),
		.frame (frame)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Any fiber value but the sync word
	function automatic logic [`CRATE_FIBER_W-1:0] idle_word();
		logic [31:0] draw;
		draw = $urandom;
		while (draw[`CRATE_FIBER_W-1:0] == `CRATE_SYNC_WORD)
		begin
			draw = $urandom;
		end
		return draw[`CRATE_FIBER_W-1:0];
	endfunction

	task automatic load_stimulus(output bit ok);
		int fd;
		int code;
		int cur;
		int pos;
		string tok;
		string rest;
		logic [63:0] value;
		ok = 1'b1;
		cur = -1;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			$display("Cannot open the stimulus file %s", STIM_FILE);
			ok = 1'b0;
			return;
		end
		while (ok && $fscanf(fd, " %s", tok) == 1)
		begin
			if (tok[0] == "#")
			begin
				code = $fgets(rest, fd);
			end
			else if (tok == "TEST" && num_tests < MAX_TESTS)
			begin
				cur = num_tests;
				num_tests++;
				code = $fscanf(fd, " %s", rest);
				ok = (code == 1);
				test_name[cur] = rest;
				idle_cycles[cur] = DEFAULT_IDLE;
				reset_at[cur] = -1;
				frame_fiber[cur] = '0;
				expect_frame[cur] = 1'b1;
				exp_header[cur] = '0;
				exp_map[cur] = '0;
				for (int i = 0; i < `CRATE_COLLECT_CYCLES; i++)
				begin
					chan_line[cur][i] = '0;
				end
			end
			else if (cur < 0)
			begin
				ok = 1'b0;
			end
			else if (tok == "IDLE")
			begin
				code = $fscanf(fd, " %d", idle_cycles[cur]);
				ok = (code == 1);
			end
			else if (tok == "RESET")
			begin
				code = $fscanf(fd, " %d", reset_at[cur]);
				ok = (code == 1);
			end
			else if (tok == "CH")
			begin
				code = $fscanf(fd, " %d", pos);
				ok = (code == 1) && (pos >= 0) && (pos < `CRATE_COLLECT_CYCLES);
				for (int ch = 0; ok && ch < `CRATE_CHANNELS; ch++)
				begin
					code = $fscanf(fd, " %h", value);
					ok = (code == 1);
					chan_line[cur][pos][ch] = value[15:0];
				end
			end
			else if (tok == "FIBER")
			begin
				code = $fscanf(fd, " %h", value);
				ok = (code == 1);
				frame_fiber[cur] = value[`CRATE_FIBER_W-1:0];
			end
			else if (tok == "HDR")
			begin
				code = $fscanf(fd, " %h", value);
				ok = (code == 1);
				exp_header[cur] = value[`CRATE_COLS-1:0];
			end
			else if (tok == "ROW")
			begin
				code = $fscanf(fd, " %d %h", pos, value);
				ok = (code == 2) && (pos >= 0) && (pos < `CRATE_ROWS);
				if (ok)
				begin
					exp_map[cur][pos] = value[`CRATE_COLS-1:0];
				end
			end
			else if (tok == "NOFRAME")
			begin
				expect_frame[cur] = 1'b0;
			end
			else
			begin
				ok = 1'b0;
			end
			if (!ok)
			begin
				$display("Stimulus file has a bad or misplaced entry at %s", tok);
			end
		end
		$fclose(fd);
		ok = ok && (num_tests > 0);
	endtask

	task automatic compare_header(input string name,
		input crate_frame_pkg::frame_header_t expected,
		input crate_frame_pkg::frame_header_t actual);
		if (actual !== expected)
		begin
			$display("** Error: %s header expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic compare_map(input string name, input crate_hit_pkg::hit_map_t expected,
		input crate_hit_pkg::hit_map_t actual);
		for (int r = 0; r < `CRATE_ROWS; r++)
		begin
			if (actual[r] !== expected[r])
			begin
				$display("** Error: %s map row %0d expected %h, actual %h",
					name, r + 1, expected[r], actual[r]);
				error_count++;
			end
		end
	endtask

	task automatic compare_latency(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("** Error: %s frame latency expected %0d, actual %0d",
				name, expected, actual);
			error_count++;
		end
	endtask

	task automatic run_test(input int t);
		int since_sync;
		int errors_before;
		bit seen;
		crate_frame_pkg::frame_t captured;
		errors_before = error_count;
		seen = 1'b0;
		captured = '0;
		repeat (idle_cycles[t])
		begin
			@(posedge clk);
			fiber <= idle_word();
			channels <= '0;
		end
		@(posedge clk);
		fiber <= `CRATE_SYNC_WORD;
		channels <= '0;
		// Each line lands one edge after it is driven, reset lasts two cycles
		for (int i = 0; i < `CRATE_COLLECT_CYCLES; i++)
		begin
			@(posedge clk);
			fiber <= idle_word();
			channels <= chan_line[t][i];
			reset <= (reset_at[t] >= 0) && (i >= reset_at[t]) && (i < reset_at[t] + 2);
		end
		@(posedge clk);
		fiber <= frame_fiber[t];
		channels <= '0;
		reset <= 1'b0;
		since_sync = `CRATE_COLLECT_CYCLES;
		while (!seen && since_sync < `CRATE_COLLECT_CYCLES + FRAME_WAIT)
		begin
			@(posedge clk);
			since_sync++;
			@(negedge clk);
			if (frame_valid)
			begin
				seen = 1'b1;
				captured = frame;
			end
		end
		if (expect_frame[t] && !seen)
		begin
			$display("%s: no frame came out within %0d cycles of the sync word",
				test_name[t], since_sync);
			error_count++;
		end
		else if (!expect_frame[t] && seen)
		begin
			$display("%s: a frame came out although none was expected", test_name[t]);
			error_count++;
		end
		else if (seen)
		begin
			compare_latency(test_name[t], EXPECT_LATENCY, since_sync);
			compare_header(test_name[t], exp_header[t], captured.header);
			compare_map(test_name[t], exp_map[t], captured.rows);
		end
		if (error_count == errors_before)
		begin
			pass_count++;
			$display("PASS %s", test_name[t]);
		end
		else
		begin
			fail_count++;
			$display("FAIL %s", test_name[t]);
		end
	endtask

	initial
	begin
		reset = 1'b1;
		fiber = '0;
		channels = '0;
		void'($urandom(32'h1b2d_1e2a));
		load_stimulus(load_ok);
		if (load_ok)
		begin
			stim_loaded = 1'b1;
			repeat (RESET_CYCLES) @(posedge clk);
			reset <= 1'b0;
			for (int t = 0; t < num_tests; t++)
			begin
				run_test(t);
			end
		end
		else
		begin
			$display("The stimulus file could not be read, so no test was run");
		end
		$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
			pass_count + fail_count, pass_count, fail_count, error_count,
			u_crate_mapper.u_chk.assert_failures);
		if (load_ok && fail_count == 0 && u_crate_mapper.u_chk.assert_failures == 0)
		begin
			$display("*** TEST PASSED ***");
		end
		else
		begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Run limit scales with the number of tests
	initial
	begin
		wait (stim_loaded);
		#(num_tests * CYCLES_PER_TEST * CLK_PERIOD + 1000);
		$display("Watchdog expired, the run did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/crate_mapper_stimulus.txt ====
# TEST name [IDLE n] [RESET k], then CH cycle and 16 channel words in hex, channel 0 first
# FIBER frame-cycle fiber, then HDR and ROW index hex (index 0 is map row 1), or NOFRAME
TEST single_hit
CH 0 0000 0000 0000 0000 0000 0000 0000 1284 0000 0000 0000 0000 0000 0000 0000 0000
FIBER 1234
HDR 300234AAAA
ROW 4 0000000800

TEST several_hits
CH 0 1000 0000 0000 0000 0000 1911 0000 0000 0000 0000 0000 0000 0000 0000 0000 1284
CH 7 0000 0000 0000 1284 0000 0000 0000 0000 0000 12C4 0000 0000 1284 0000 0000 0000
CH 15 0000 1509 1000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
FIBER 0155
HDR 300155AAAA
ROW 0 0000000002
ROW 4 0000001800
ROW 9 0000200000
ROW 17 2000000000

TEST rejected_hits
CH 2 0284 E284 1152 117F 1942 1FC2 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
CH 9 0000 0000 0000 0000 0000 0000 0000 0000 1911 0000 0000 0000 0000 0000 0000 0000
FIBER FFFF
HDR 3003FFAAAA
ROW 17 2000000000

TEST sync_in_frame_cycle
CH 3 0000 0000 0000 0000 0000 0000 1081 0000 0000 0000 0000 0000 0000 0000 0000 0000
CH 12 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 178C 0000 0000 0000 0000 0000
FIBER AAAA
HDR 3002AAAAAA
ROW 1 0000000008
ROW 12 0080000000

TEST back_to_back IDLE 0
CH 0 1142 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
FIBER 0C01
HDR 300001AAAA
ROW 2 0000000040

TEST reset_mid_collect RESET 8
CH 2 1284 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
CH 12 0000 1284 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
FIBER 0000
NOFRAME

TEST after_reset IDLE 3
CH 5 1900 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1011
FIBER 8200
HDR 300200AAAA
ROW 0 2000000000
ROW 17 0000000002

// ==== src.f ====
+incdir+hdl
hdl/crate_hit_pkg.sv
hdl/crate_frame_pkg.sv
hdl/crate_hit_decoder.sv
hdl/crate_hitmap_accumulator.sv
hdl/crate_frame_sequencer.sv
hdl/crate_mapper.sv
tb/crate_mapper_chk.sv
tb/crate_mapper_tb.sv

// ==== Bender.yml ====
package:
  name: crate_mapper

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/crate_hit_pkg.sv
      - hdl/crate_frame_pkg.sv
      - hdl/crate_hit_decoder.sv
      - hdl/crate_hitmap_accumulator.sv
      - hdl/crate_frame_sequencer.sv
      - hdl/crate_mapper.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/crate_mapper_chk.sv
      - tb/crate_mapper_tb.sv
